//--- ex_pkg.sv
`default_nettype none

package ex_pkg;

    // datapath widths
    localparam int XLEN       = 32;   // data and address
    localparam int REG_ADDR_W = 5;    // gpr index
    localparam int TIME_W     = 64;   // stable counter
    localparam int STRB_W     = 4;    // byte strobes per word

    // alu operations, decode picks one per instruction
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_NOR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_MUL          // low word only
    } alu_op_e;

    // load / store kinds
    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LD_W,
        MEM_LD_B,
        MEM_LD_BU,
        MEM_LD_H,
        MEM_LD_HU,
        MEM_ST_W,
        MEM_ST_B,
        MEM_ST_H
    } mem_op_e;

    // divider ops, none means alu or mem path
    typedef enum logic [2:0] {
        DIV_NONE,
        DIV_W,
        DIV_WU,
        MOD_W,
        MOD_WU
    } div_op_e;

    // rdcntvl / rdcntvh select
    typedef enum logic [1:0] {
        RDCNT_NONE,
        RDCNT_LOW,
        RDCNT_HIGH
    } rdcnt_e;

    // sram size field encoding
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    function automatic logic is_load_op(mem_op_e op);
        return op inside {MEM_LD_W, MEM_LD_B, MEM_LD_BU, MEM_LD_H, MEM_LD_HU};
    endfunction

    function automatic logic is_store_op(mem_op_e op);
        return op inside {MEM_ST_W, MEM_ST_B, MEM_ST_H};
    endfunction

endpackage

`default_nettype wire

//--- ex_alu.sv
`default_nettype none

module ex_alu
    import ex_pkg::*;
(
    input  alu_op_e         alu_op,
    input  logic [XLEN-1:0] src1,
    input  logic [XLEN-1:0] src2,
    output logic [XLEN-1:0] result
);

    logic [4:0]      shamt;      // shift amount from src2 low bits
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic [XLEN-1:0] mul_low;
    logic            lt_signed;
    logic            lt_unsigned;

    assign shamt = src2[4:0];
    assign sum   = src1 + src2;
    assign diff  = src1 - src2;

    // low word is the same for signed and unsigned
    assign mul_low = src1 * src2;

    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb
    begin
        case (alu_op)
            ALU_ADD:  result = sum;
            ALU_SUB:  result = diff;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};     // 0 or 1
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_AND:  result = src1 & src2;
            ALU_OR:   result = src1 | src2;
            ALU_NOR:  result = ~(src1 | src2);
            ALU_XOR:  result = src1 ^ src2;
            ALU_SLL:  result = src1 << shamt;
            ALU_SRL:  result = src1 >> shamt;
            ALU_SRA:  result = $unsigned($signed(src1) >>> shamt);  // keep sign bit
            // decode already placed the upper immediate in src2
            ALU_LUI:  result = src2;
            ALU_MUL:  result = mul_low;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- ex_divider.sv
`default_nettype none

module ex_divider
    import ex_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            flush,
    input  logic            start,
    input  div_op_e         div_op,
    input  logic [XLEN-1:0] dividend,
    input  logic [XLEN-1:0] divisor,
    output logic [XLEN-1:0] result,
    output logic            result_valid
);

    logic            busy;
    logic [5:0]      step;        // 0..31 shift steps, 32 is sign fix
    logic [XLEN-1:0] rem;         // partial remainder
    logic [XLEN-1:0] quo;         // dividend shifts out, quotient shifts in
    logic [XLEN-1:0] dvs;         // divisor magnitude
    logic            neg_q;
    logic            neg_r;
    logic            is_mod;

    logic            op_signed;
    logic [XLEN-1:0] a_mag;
    logic [XLEN-1:0] b_mag;
    logic [XLEN:0]   partial;
    logic [XLEN:0]   trial;
    logic            fix_step;

    assign op_signed = (div_op == DIV_W) || (div_op == MOD_W);

    // magnitudes for the unsigned core
    assign a_mag = (op_signed && dividend[XLEN-1]) ? -dividend : dividend;
    assign b_mag = (op_signed && divisor[XLEN-1])  ? -divisor  : divisor;

    // bring down next dividend bit and try subtracting
    assign partial = {rem, quo[XLEN-1]};
    assign trial   = partial - {1'b0, dvs};

    assign fix_step = step[5];    // all 32 steps done

    // control
    always_ff @(posedge clk)
    begin
        if (reset || flush)
        begin
            busy         <= 1'b0;
            result_valid <= 1'b0;
        end
        else if (start)
        begin
            busy         <= 1'b1;
            result_valid <= 1'b0;    // old result gone on new op
        end
        else if (busy && fix_step)
        begin
            busy         <= 1'b0;
            result_valid <= 1'b1;    // held until next start or flush
        end
    end

    // datapath
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            step   <= '0;
            rem    <= '0;
            quo    <= a_mag;
            dvs    <= b_mag;
            neg_q  <= op_signed && (dividend[XLEN-1] ^ divisor[XLEN-1]);
            neg_r  <= op_signed && dividend[XLEN-1];   // remainder follows dividend
            is_mod <= (div_op == MOD_W) || (div_op == MOD_WU);
        end
        else if (busy && !fix_step)
        begin
            step <= step + 6'd1;
            // divide by zero never goes negative so quotient ends all ones
            if (!trial[XLEN])
            begin
                rem <= trial[XLEN-1:0];
                quo <= {quo[XLEN-2:0], 1'b1};
            end
            else
            begin
                rem <= partial[XLEN-1:0];
                quo <= {quo[XLEN-2:0], 1'b0};
            end
        end
        else if (busy)
        begin
            if (is_mod)
                result <= neg_r ? -rem : rem;
            else
                result <= neg_q ? -quo : quo;
        end
    end

endmodule

`default_nettype wire

//--- ex_mem_req.sv
`default_nettype none

module ex_mem_req
    import ex_pkg::*;
(
    input  mem_op_e           mem_op,
    input  logic [XLEN-1:0]   addr,
    input  logic [XLEN-1:0]   store_data,
    output mem_size_e         size,
    output logic [STRB_W-1:0] wstrb,
    output logic [XLEN-1:0]   wdata,
    output logic              wr,
    output logic              is_mem,
    output logic              ale
);

    logic word_op;
    logic half_op;
    logic is_load;

    assign is_load = is_load_op(mem_op);
    assign wr      = is_store_op(mem_op);
    assign is_mem  = is_load || wr;

    assign word_op = (mem_op == MEM_LD_W) || (mem_op == MEM_ST_W);
    assign half_op = (mem_op == MEM_LD_H) || (mem_op == MEM_LD_HU) || (mem_op == MEM_ST_H);

    // byte ops may sit at any offset
    assign ale = (word_op && (addr[1:0] != 2'b00)) || (half_op && addr[0]);

    always_comb
    begin
        if (word_op)
            size = SIZE_WORD;
        else if (half_op)
            size = SIZE_HALF;
        else
            size = SIZE_BYTE;   // byte ops and no-op
    end

    // strobes only for stores
    always_comb
    begin
        case (mem_op)
            MEM_ST_W: wstrb = 4'b1111;
            MEM_ST_B: wstrb = 4'b0001 << addr[1:0];   // one lane by offset
            MEM_ST_H: wstrb = addr[1] ? 4'b1100 : 4'b0011;
            default:  wstrb = 4'b0000;
        endcase
    end

    // narrow stores replicated so any lane carries the data
    always_comb
    begin
        case (mem_op)
            MEM_ST_W: wdata = store_data;
            MEM_ST_B: wdata = {4{store_data[7:0]}};
            MEM_ST_H: wdata = {2{store_data[15:0]}};
            default:  wdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- ex_stage.sv
`default_nettype none

module ex_stage
    import ex_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,

    // from decode
    input  logic                  in_valid,
    output logic                  allow_in,
    input  logic [XLEN-1:0]       pc,
    input  logic [XLEN-1:0]       rj_value,
    input  logic [XLEN-1:0]       rkd_value,
    input  logic [XLEN-1:0]       imm,
    input  logic [REG_ADDR_W-1:0] dest,
    input  logic                  gr_we,
    input  alu_op_e               alu_op,
    input  logic                  src1_is_pc,
    input  logic                  src2_is_imm,
    input  mem_op_e               mem_op,
    input  div_op_e               div_op,
    input  rdcnt_e                rdcnt,

    input  logic [TIME_W-1:0]     time_cnt,

    // to memory stage
    input  logic                  next_allow_in,
    output logic                  out_valid,
    output logic [XLEN-1:0]       out_pc,
    output logic                  out_gr_we,
    output logic [REG_ADDR_W-1:0] out_dest,
    output logic [XLEN-1:0]       out_result,
    output mem_op_e               out_mem_op,
    output logic                  out_ale,
    output logic [1:0]            out_addr_low,

    // data sram
    output logic                  data_sram_req,
    output logic                  data_sram_wr,
    output mem_size_e             data_sram_size,
    output logic [STRB_W-1:0]     data_sram_wstrb,
    output logic [XLEN-1:0]       data_sram_addr,
    output logic [XLEN-1:0]       data_sram_wdata,
    input  logic                  data_sram_addr_ok,

    // forwarding back to decode
    output logic                  fwd_valid,
    output logic                  fwd_we,
    output logic [REG_ADDR_W-1:0] fwd_dest,
    output logic                  fwd_is_load,
    output logic [XLEN-1:0]       fwd_result
);

    logic                  es_valid;
    logic                  just_loaded;   // first cycle of the held item
    logic [XLEN-1:0]       es_pc;
    logic [XLEN-1:0]       es_rj_value;
    logic [XLEN-1:0]       es_rkd_value;
    logic [XLEN-1:0]       es_imm;
    logic [REG_ADDR_W-1:0] es_dest;
    logic                  es_gr_we;
    alu_op_e               es_alu_op;
    logic                  es_src1_is_pc;
    logic                  es_src2_is_imm;
    mem_op_e               es_mem_op;
    div_op_e               es_div_op;
    rdcnt_e                es_rdcnt;

    logic [XLEN-1:0] alu_src1;
    logic [XLEN-1:0] alu_src2;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] mem_addr;
    logic [XLEN-1:0] div_result;
    logic            div_result_valid;
    logic            div_start;
    logic            div_done;
    logic [XLEN-1:0] cnt_word;
    logic [XLEN-1:0] calc_result;
    logic            is_mem;
    logic            mem_ale;
    logic            ale;
    logic            is_div;
    logic            accept;
    logic            ready_go;

    assign accept = in_valid && allow_in;

    // valid bit, flush wins over a same-cycle accept
    always_ff @(posedge clk)
    begin
        if (reset || flush)
            es_valid <= 1'b0;
        else if (allow_in)
            es_valid <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            just_loaded <= 1'b0;
        else
            just_loaded <= accept && !flush;
    end

    // stage register payload
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            es_pc          <= pc;
            es_rj_value    <= rj_value;
            es_rkd_value   <= rkd_value;
            es_imm         <= imm;
            es_dest        <= dest;
            es_gr_we       <= gr_we;
            es_alu_op      <= alu_op;
            es_src1_is_pc  <= src1_is_pc;
            es_src2_is_imm <= src2_is_imm;
            es_mem_op      <= mem_op;
            es_div_op      <= div_op;
            es_rdcnt       <= rdcnt;
        end
    end

    assign alu_src1 = es_src1_is_pc  ? es_pc  : es_rj_value;
    assign alu_src2 = es_src2_is_imm ? es_imm : es_rkd_value;
    assign mem_addr = alu_src1 + alu_src2;   // base plus offset

    ex_alu u_alu (
        .alu_op (es_alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    assign is_div    = es_div_op != DIV_NONE;
    assign div_start = just_loaded && es_valid && is_div;   // one pulse per divide op
    // result_valid from the previous op still up during the start cycle
    assign div_done  = div_result_valid && !just_loaded;

    ex_divider u_divider (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .start        (div_start),
        .div_op       (es_div_op),
        .dividend     (es_rj_value),
        .divisor      (es_rkd_value),
        .result       (div_result),
        .result_valid (div_result_valid)
    );

    ex_mem_req u_mem_req (
        .mem_op     (es_mem_op),
        .addr       (mem_addr),
        .store_data (es_rkd_value),
        .size       (data_sram_size),
        .wstrb      (data_sram_wstrb),
        .wdata      (data_sram_wdata),
        .wr         (data_sram_wr),
        .is_mem     (is_mem),
        .ale        (mem_ale)
    );

    assign ale = es_valid && mem_ale;

    // counter word, then divider, then alu
    assign cnt_word    = (es_rdcnt == RDCNT_HIGH) ? time_cnt[TIME_W-1:XLEN]
                                                  : time_cnt[XLEN-1:0];
    assign calc_result = (es_rdcnt != RDCNT_NONE) ? cnt_word
                       : is_div                   ? div_result
                       : alu_result;

    // request only when memory stage can take the item on addr_ok
    assign data_sram_req  = es_valid && is_mem && !mem_ale && next_allow_in;
    assign data_sram_addr = mem_addr;

    always_comb
    begin
        if (mem_ale)
            ready_go = 1'b1;   // goes on at once with no request
        else if (is_mem)
            ready_go = data_sram_req && data_sram_addr_ok;
        else if (is_div)
            ready_go = div_done;
        else
            ready_go = 1'b1;
    end

    assign allow_in  = !es_valid || (ready_go && next_allow_in);
    assign out_valid = es_valid && ready_go;

    assign out_pc       = es_pc;
    assign out_gr_we    = es_gr_we && !ale;   // no writeback on misaligned load
    assign out_dest     = es_dest;
    assign out_result   = calc_result;
    assign out_mem_op   = es_mem_op;
    assign out_ale      = ale;
    assign out_addr_low = mem_addr[1:0];

    assign fwd_valid   = es_valid;
    assign fwd_we      = es_gr_we;
    assign fwd_dest    = es_dest;
    assign fwd_is_load = is_load_op(es_mem_op);   // decode stalls instead of forwarding
    assign fwd_result  = calc_result;

endmodule

`default_nettype wire

//--- tb_ex_stage.sv
`default_nettype none

module tb_ex_stage
    import ex_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_OPS        = 300;   // room above the ~115 ops issued
    localparam int MAX_OP_CYCLES  = 60;    // divide plus stall is the longest op
    localparam int TIMEOUT_CYCLES = MAX_OPS * MAX_OP_CYCLES + 2000;
    localparam logic [31:0] SEED  = 32'd21906;

    logic clk = 1'b0;
    logic reset, flush, in_valid, allow_in, gr_we, src1_is_pc, src2_is_imm;
    logic [XLEN-1:0] pc, rj_value, rkd_value, imm;
    logic [REG_ADDR_W-1:0] dest;
    alu_op_e alu_op;
    mem_op_e mem_op;
    div_op_e div_op;
    rdcnt_e rdcnt;
    logic [TIME_W-1:0] time_cnt;
    logic next_allow_in, out_valid, out_gr_we, out_ale;
    logic [XLEN-1:0] out_pc, out_result;
    logic [REG_ADDR_W-1:0] out_dest;
    mem_op_e out_mem_op;
    logic [1:0] out_addr_low;
    logic data_sram_req, data_sram_wr, data_sram_addr_ok;
    mem_size_e data_sram_size;
    logic [STRB_W-1:0] data_sram_wstrb;
    logic [XLEN-1:0] data_sram_addr, data_sram_wdata;
    logic fwd_valid, fwd_we, fwd_is_load;
    logic [REG_ADDR_W-1:0] fwd_dest;
    logic [XLEN-1:0] fwd_result;

    logic [31:0] rng_state;
    int error_count = 0;
    int check_count = 0;
    int op_count = 0;
    int test_count = 0;
    int cycle_count = 0;

    ex_stage dut (.*);

    always #10 clk = ~clk;   // 20 ns period

    // watchdog
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run still going after %0d cycles", cycle_count);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_word(input string what, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("ERROR %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_strb(input string what, input logic [STRB_W-1:0] got,
                              input logic [STRB_W-1:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("ERROR %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_size(input string what, input mem_size_e got, input mem_size_e exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("ERROR %0t ns: %s got %s expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("ERROR %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_dest(input string what, input logic [REG_ADDR_W-1:0] got,
                              input logic [REG_ADDR_W-1:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("ERROR %0t ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_mem_op(input string what, input mem_op_e got, input mem_op_e exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("ERROR %0t ns: %s got %s expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_addr_low(input string what, input logic [1:0] got,
                                  input logic [1:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("ERROR %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // reference alu written from the op definitions
    function automatic logic [XLEN-1:0] alu_model(alu_op_e op, logic [XLEN-1:0] a,
                                                  logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] prod;
        logic [4:0] sh;
        sh = b[4:0];
        prod = {32'd0, a} * {32'd0, b};
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 32'd1;
            ALU_SLT:  return {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU: return {31'd0, a < b};
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_NOR:  return ~(a | b);
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
            ALU_LUI:  return b;
            ALU_MUL:  return prod[31:0];
            default:  return '0;
        endcase
    endfunction

    // magnitude divide then sign fix
    // zero divisor gives all ones and the dividend
    function automatic logic [XLEN-1:0] div_model(div_op_e op, logic [XLEN-1:0] a,
                                                  logic [XLEN-1:0] b);
        logic sgn;
        logic [XLEN-1:0] a_mag, b_mag, q, r;
        sgn = (op == DIV_W) || (op == MOD_W);
        a_mag = (sgn && a[31]) ? ~a + 32'd1 : a;
        b_mag = (sgn && b[31]) ? ~b + 32'd1 : b;
        if (b_mag == '0)
        begin
            q = '1;
            r = a_mag;
        end
        else
        begin
            q = a_mag / b_mag;
            r = a_mag % b_mag;
        end
        if (sgn && (a[31] ^ b[31]))
            q = ~q + 32'd1;
        if (sgn && a[31])
            r = ~r + 32'd1;   // remainder keeps dividend sign
        return (op == MOD_W || op == MOD_WU) ? r : q;
    endfunction

    function automatic logic misaligned(mem_op_e op, logic [1:0] lo);
        if (op == MEM_LD_W || op == MEM_ST_W)
            return lo != 2'b00;
        if (op == MEM_LD_H || op == MEM_LD_HU || op == MEM_ST_H)
            return lo[0];
        return 1'b0;   // bytes go anywhere
    endfunction

    function automatic mem_size_e size_model(mem_op_e op);
        if (op == MEM_LD_W || op == MEM_ST_W)
            return SIZE_WORD;
        if (op == MEM_LD_H || op == MEM_LD_HU || op == MEM_ST_H)
            return SIZE_HALF;
        return SIZE_BYTE;
    endfunction

    function automatic logic [STRB_W-1:0] strb_model(mem_op_e op, logic [1:0] lo);
        logic [STRB_W-1:0] s;
        s = '0;
        if (op == MEM_ST_W)
            s = 4'b1111;
        else if (op == MEM_ST_B)
            s[lo] = 1'b1;   // single lane
        else if (op == MEM_ST_H)
            s = lo[1] ? 4'b1100 : 4'b0011;
        return s;
    endfunction

    function automatic logic [XLEN-1:0] wdata_model(mem_op_e op, logic [XLEN-1:0] d);
        if (op == MEM_ST_B)
            return {d[7:0], d[7:0], d[7:0], d[7:0]};
        if (op == MEM_ST_H)
            return {d[15:0], d[15:0]};
        return d;
    endfunction

    task automatic set_idle();
        in_valid = 1'b0;
        flush = 1'b0;
        pc = '0;
        rj_value = '0;
        rkd_value = '0;
        imm = '0;
        dest = 5'd1;
        gr_we = 1'b1;
        alu_op = ALU_ADD;
        src1_is_pc = 1'b0;
        src2_is_imm = 1'b0;
        mem_op = MEM_NONE;
        div_op = DIV_NONE;
        rdcnt = RDCNT_NONE;
    endtask

    // offer one op and return just after the transfer edge
    task automatic send_op();
        in_valid = 1'b1;
        @(negedge clk);
        while (!allow_in)
            @(negedge clk);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        op_count++;
    endtask

    task automatic report_test(input string name, input int errs_before, input int ops_before);
        test_count++;
        $display("test %s: %0d ops, %0d errors", name, op_count - ops_before,
                 error_count - errs_before);
    endtask

    task automatic run_alu_op(input alu_op_e op, input logic [XLEN-1:0] a_pc, a_rj, a_rk,
                              a_imm, input logic s1pc, s2imm);
        logic [XLEN-1:0] expected;
        logic [31:0] r;
        expected = alu_model(op, s1pc ? a_pc : a_rj, s2imm ? a_imm : a_rk);
        r = xorshift32();
        alu_op = op;
        pc = a_pc;
        rj_value = a_rj;
        rkd_value = a_rk;
        imm = a_imm;
        src1_is_pc = s1pc;
        src2_is_imm = s2imm;
        dest = r[4:0];
        gr_we = r[5];
        send_op();
        @(negedge clk);   // first cycle after acceptance
        check_flag("alu out_valid", out_valid, 1'b1);
        check_word("alu out_result", out_result, expected);
        check_word("alu fwd_result", fwd_result, expected);
        check_word("alu out_pc", out_pc, a_pc);
        check_dest("alu out_dest", out_dest, r[4:0]);
        check_dest("alu fwd_dest", fwd_dest, r[4:0]);
        check_flag("alu out_gr_we", out_gr_we, r[5]);
        check_flag("alu fwd_we", fwd_we, r[5]);
        check_flag("alu fwd_valid", fwd_valid, 1'b1);
        @(posedge clk);
        #1;
    endtask

    task automatic test_alu();
        int errs_before, ops_before;
        logic [31:0] r;
        errs_before = error_count;
        ops_before = op_count;
        for (int i = 0; i <= 12; i++)
        begin
            for (int k = 0; k < 4; k++)
            begin
                r = xorshift32();
                run_alu_op(alu_op_e'(i[3:0]), xorshift32(), xorshift32(), xorshift32(),
                           xorshift32(), r[0], r[1]);
            end
        end
        set_idle();
        report_test("alu", errs_before, ops_before);
    endtask

    task automatic test_rdcnt();
        int errs_before, ops_before;
        logic [31:0] hi, lo;
        errs_before = error_count;
        ops_before = op_count;
        for (int k = 0; k < 4; k++)
        begin
            hi = xorshift32();
            lo = xorshift32();
            time_cnt = {hi, lo};
            rdcnt = k[0] ? RDCNT_HIGH : RDCNT_LOW;
            send_op();
            @(negedge clk);
            check_flag("rdcnt out_valid", out_valid, 1'b1);
            check_word("rdcnt out_result", out_result, k[0] ? hi : lo);
            @(posedge clk);
            #1;
        end
        set_idle();
        report_test("rdcnt", errs_before, ops_before);
    endtask

    task automatic test_div();
        int errs_before, ops_before, hold;
        div_op_e op;
        logic [XLEN-1:0] a, b, expected;
        errs_before = error_count;
        ops_before = op_count;
        for (int i = 1; i <= 4; i++)
        begin
            for (int k = 0; k < 6; k++)
            begin
                op = div_op_e'(i[2:0]);
                a = xorshift32();
                b = xorshift32();
                b = b >> (xorshift32() % 32'd32);   // spread of quotient sizes
                if (k == 5)
                    b = '0;
                if ((op == DIV_W || op == MOD_W) && a == 32'h8000_0000 && b == '1)
                    b = 32'd3;   // min / -1 left out
                expected = div_model(op, a, b);
                div_op = op;
                rj_value = a;
                rkd_value = b;
                send_op();
                next_allow_in = 1'b0;   // memory stage stalls over the result
                @(negedge clk);
                while (!out_valid)
                    @(negedge clk);
                check_word("div out_result", out_result, expected);
                hold = int'(xorshift32() % 32'd4) + 1;
                repeat (hold)
                begin
                    @(negedge clk);
                    check_flag("div held out_valid", out_valid, 1'b1);
                    check_flag("div held allow_in", allow_in, 1'b0);
                    check_word("div held out_result", out_result, expected);
                end
                @(posedge clk);
                #1;
                next_allow_in = 1'b1;
                @(negedge clk);
                check_flag("div release out_valid", out_valid, 1'b1);
                check_word("div release out_result", out_result, expected);
                @(posedge clk);
                #1;
            end
        end
        set_idle();
        report_test("div", errs_before, ops_before);
    endtask

    // aligned base plus an offset whose low bits are lo
    task automatic setup_mem(input mem_op_e op, input logic [1:0] lo,
                             output logic [XLEN-1:0] addr, output logic [XLEN-1:0] data);
        logic [XLEN-1:0] base, ofs;
        base = xorshift32() & 32'hffff_fffc;
        ofs = (xorshift32() & 32'h0000_07fc) | {30'd0, lo};
        data = xorshift32();
        addr = base + ofs;
        mem_op = op;
        rj_value = base;
        imm = ofs;
        rkd_value = data;
        src2_is_imm = 1'b1;
    endtask

    task automatic test_mem();
        int errs_before, ops_before, delay;
        mem_op_e op;
        logic [1:0] lo;
        logic [XLEN-1:0] addr, data;
        logic is_st;
        logic is_ld;
        errs_before = error_count;
        ops_before = op_count;
        for (int i = 1; i <= 8; i++)
        begin
            for (int k = 0; k < 4; k++)
            begin
                op = mem_op_e'(i[3:0]);
                lo = k[1:0];
                is_st = (op == MEM_ST_W) || (op == MEM_ST_B) || (op == MEM_ST_H);
                is_ld = (op != MEM_NONE) && !is_st;
                if (!misaligned(op, lo))
                begin
                    setup_mem(op, lo, addr, data);
                    delay = int'(xorshift32() % 32'd5);
                    send_op();
                    repeat (delay)
                    begin
                        @(negedge clk);
                        check_flag("mem req waiting", data_sram_req, 1'b1);
                        check_flag("mem out_valid waiting", out_valid, 1'b0);
                        check_word("mem addr waiting", data_sram_addr, addr);
                        @(posedge clk);
                        #1;
                    end
                    data_sram_addr_ok = 1'b1;
                    @(negedge clk);
                    check_flag("mem req", data_sram_req, 1'b1);
                    check_flag("mem out_valid", out_valid, 1'b1);
                    check_flag("mem wr", data_sram_wr, is_st);
                    check_size("mem size", data_sram_size, size_model(op));
                    check_strb("mem wstrb", data_sram_wstrb, strb_model(op, lo));
                    check_word("mem addr", data_sram_addr, addr);
                    if (is_st)
                        check_word("mem wdata", data_sram_wdata, wdata_model(op, data));
                    check_flag("mem out_ale", out_ale, 1'b0);
                    check_flag("mem fwd_is_load", fwd_is_load, is_ld);
                    check_mem_op("mem out_mem_op", out_mem_op, op);
                    check_addr_low("mem out_addr_low", out_addr_low, lo);
                    @(posedge clk);
                    #1;
                    data_sram_addr_ok = 1'b0;
                end
            end
        end
        set_idle();
        report_test("mem", errs_before, ops_before);
    endtask

    task automatic test_misaligned();
        int errs_before, ops_before;
        mem_op_e op;
        logic [1:0] lo;
        logic [XLEN-1:0] addr, data;
        errs_before = error_count;
        ops_before = op_count;
        data_sram_addr_ok = 1'b1;   // a stray request would be taken at once
        for (int i = 1; i <= 8; i++)
        begin
            for (int k = 1; k < 4; k++)
            begin
                op = mem_op_e'(i[3:0]);
                lo = k[1:0];
                if (misaligned(op, lo))
                begin
                    setup_mem(op, lo, addr, data);
                    send_op();
                    @(negedge clk);
                    check_flag("ale out_valid", out_valid, 1'b1);
                    check_flag("ale out_ale", out_ale, 1'b1);
                    check_flag("ale out_gr_we", out_gr_we, 1'b0);
                    check_flag("ale data_sram_req", data_sram_req, 1'b0);
                    check_mem_op("ale out_mem_op", out_mem_op, op);
                    check_addr_low("ale out_addr_low", out_addr_low, lo);
                    @(posedge clk);
                    #1;
                end
            end
        end
        data_sram_addr_ok = 1'b0;
        set_idle();
        report_test("ale", errs_before, ops_before);
    endtask

    task automatic test_flush();
        int errs_before, ops_before;
        errs_before = error_count;
        ops_before = op_count;
        div_op = DIV_W;
        rj_value = xorshift32();
        rkd_value = 32'd7;
        send_op();
        repeat (3)
        begin
            @(negedge clk);
            check_flag("flush out_valid before", out_valid, 1'b0);
        end
        @(posedge clk);
        #1;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        div_op = DIV_NONE;
        // well past any division length
        repeat (40)
        begin
            @(negedge clk);
            check_flag("flush out_valid after", out_valid, 1'b0);
            check_flag("flush fwd_valid after", fwd_valid, 1'b0);
        end
        @(posedge clk);
        #1;
        run_alu_op(ALU_ADD, xorshift32(), xorshift32(), xorshift32(), xorshift32(), 1'b0, 1'b0);
        set_idle();
        report_test("flush", errs_before, ops_before);
    endtask

    initial
    begin
        rng_state = SEED;
        reset = 1'b1;
        set_idle();
        time_cnt = '0;
        next_allow_in = 1'b1;
        data_sram_addr_ok = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        test_alu();
        test_rdcnt();
        test_div();
        test_mem();
        test_misaligned();
        test_flush();
        $display("summary: %0d tests, %0d ops, %0d checks, %0d errors",
                 test_count, op_count, check_count, error_count);
        if (error_count == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
ex_pkg.sv
ex_alu.sv
ex_divider.sv
ex_mem_req.sv
ex_stage.sv
tb_ex_stage.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ex_stage testbench with Verilator; the log decides the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f verilog.f --top-module tb_ex_stage -o sim_ex_stage \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_ex_stage > sim.log 2>&1
grep -q "SIMULATION PASSED" sim.log && echo "run ok, see sim.log" \
    || { echo "run failed, see sim.log"; exit 1; }
